//--- include/rv_exec_params.svh
`ifndef RV_EXEC_PARAMS_SVH
`define RV_EXEC_PARAMS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// datapath sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// data and address width.
`define RV_XLEN 32

// architectural registers, x0 included.
`define RV_NREGS 32

// recent results kept for forwarding.
`define RV_FWD_DEPTH 4

// data memory size in words.
`define RV_DMEM_WORDS 64

`endif

//--- verilog/rv_exec_pkg.sv
`include "rv_exec_params.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

    // branch ops share the adder, result is the sum.
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        SLL  = 5'd5,
        SRL  = 5'd6,
        SRA  = 5'd7,
        SLT  = 5'd8,
        SLTU = 5'd9,
        BEQ  = 5'd10,
        BNE  = 5'd11,
        BLT  = 5'd12,
        BGE  = 5'd13,
        BLTU = 5'd14,
        BGEU = 5'd15
    } alu_op_e;

    typedef enum logic {
        IDLE,
        LOAD_WAIT
    } mem_state_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        word_t    pc;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        alu_op_e  alu_op;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     is_load;
        logic     is_store;
        logic     gpr_we;
    } uop_t;

    // result holds the byte address for loads and stores.
    typedef struct packed {
        reg_idx_t rd;
        logic     gpr_we;
        logic     is_load;
        logic     is_store;
        word_t    result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     we;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

//--- verilog/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_exec_params.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_exec_pkg::wb_t      wb,
    input  rv_exec_pkg::reg_idx_t rs1,
    input  rv_exec_pkg::reg_idx_t rs2,
    output rv_exec_pkg::word_t    rdata1,
    output rv_exec_pkg::word_t    rdata2
);
    import rv_exec_pkg::*;

    word_t regs [`RV_NREGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wb.we && (wb.rd != '0)) begin
                regs[wb.rd] <= wb.data;
            end
        end
    end

    // no write-through here.
    // a result written this cycle is still in the forwarding window.
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- verilog/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv_exec_pkg::alu_op_e op,
    input  rv_exec_pkg::word_t   a,
    input  rv_exec_pkg::word_t   b,
    output rv_exec_pkg::word_t   result,
    output logic                 cond
);
    import rv_exec_pkg::*;

    localparam int SHAMT_W = $clog2($bits(word_t));

    word_t              sum;
    logic [SHAMT_W-1:0] shamt;
    logic               eq;
    logic               lt_s;
    logic               lt_u;

    assign sum   = a + b;
    assign shamt = b[SHAMT_W-1:0];
    assign eq    = (a == b);
    assign lt_s  = ($signed(a) < $signed(b));
    assign lt_u  = (a < b);

    always_comb begin
        result = sum;
        cond   = 1'b0;
        case (op)
            ADD:  result = sum;
            SUB:  result = a - b;
            AND:  result = a & b;
            OR:   result = a | b;
            XOR:  result = a ^ b;
            SLL:  result = a << shamt;
            SRL:  result = a >> shamt;
            SRA:  result = $signed(a) >>> shamt;
            SLT:  result = word_t'(lt_s);
            SLTU: result = word_t'(lt_u);
            // the sum stays on result for jump targets.
            BEQ:  cond = eq;
            BNE:  cond = !eq;
            BLT:  cond = lt_s;
            BGE:  cond = !lt_s;
            BLTU: cond = lt_u;
            BGEU: cond = !lt_u;
            default: begin
                result = sum;
                cond   = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/rv_bypass_window.sv
`timescale 1ns/1ps

`include "rv_exec_params.svh"

module rv_bypass_window (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_exec_pkg::reg_idx_t rs1,
    input  rv_exec_pkg::reg_idx_t rs2,
    input  rv_exec_pkg::word_t    rf1,
    input  rv_exec_pkg::word_t    rf2,
    input  logic                  push,
    input  logic                  push_we,
    input  logic                  push_load,
    input  rv_exec_pkg::reg_idx_t push_rd,
    input  rv_exec_pkg::word_t    push_data,
    input  logic                  load_done,
    input  rv_exec_pkg::word_t    load_data,
    output rv_exec_pkg::word_t    src1,
    output rv_exec_pkg::word_t    src2,
    output logic                  wait_load
);
    import rv_exec_pkg::*;

    typedef struct packed {
        logic     valid;
        logic     pending;
        reg_idx_t rd;
        word_t    data;
    } fwd_entry_t;

    // index 0 is the youngest entry.
    typedef fwd_entry_t [`RV_FWD_DEPTH-1:0] fwd_win_t;

    typedef struct packed {
        logic  pending;
        word_t data;
    } fwd_hit_t;

    fwd_win_t   win;
    fwd_win_t   upd;
    fwd_entry_t new_entry;
    fwd_hit_t   hit1;
    fwd_hit_t   hit2;

    function automatic fwd_hit_t lookup(input fwd_win_t w, input reg_idx_t idx,
                                        input word_t rf_val);
        fwd_hit_t r;
        logic     found;
        r.pending = 1'b0;
        r.data    = rf_val;
        found     = 1'b0;
        for (int i = 0; i < `RV_FWD_DEPTH; i++) begin
            if (!found && w[i].valid && (w[i].rd == idx) && (idx != '0)) begin
                r.pending = w[i].pending;
                r.data    = w[i].data;
                found     = 1'b1;
            end
        end
        return r;
    endfunction

    assign hit1      = lookup(win, rs1, rf1);
    assign hit2      = lookup(win, rs2, rf2);
    assign src1      = hit1.data;
    assign src2      = hit2.data;
    assign wait_load = hit1.pending | hit2.pending;

    // loads return in order, so the oldest pending entry owns the data.
    always_comb begin
        logic claimed;
        claimed = 1'b0;
        upd     = win;
        for (int i = `RV_FWD_DEPTH - 1; i >= 0; i--) begin
            if (load_done && !claimed && upd[i].valid && upd[i].pending) begin
                upd[i].data    = load_data;
                upd[i].pending = 1'b0;
                claimed        = 1'b1;
            end
        end
    end

    assign new_entry = '{valid:   push_we,
                         pending: push_we && push_load,
                         rd:      push_rd,
                         data:    push_data};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win <= '0;
        end else if (push) begin
            win <= {upd[`RV_FWD_DEPTH-2:0], new_entry};
        end else begin
            win <= upd;
        end
    end

endmodule

//--- verilog/rv_exec_stage.sv
`timescale 1ns/1ps

module rv_exec_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  rv_exec_pkg::uop_t    uop,
    input  logic                 uop_valid,
    output logic                 uop_ready,
    input  rv_exec_pkg::word_t   rf1,
    input  rv_exec_pkg::word_t   rf2,
    input  logic                 mem_ready,
    output logic                 ex_valid,
    output rv_exec_pkg::ex_mem_t ex_out,
    input  logic                 load_done,
    input  rv_exec_pkg::word_t   load_data,
    output logic                 redirect_valid,
    output rv_exec_pkg::word_t   redirect_pc,
    input  logic                 redirect_ack
);
    import rv_exec_pkg::*;

    word_t   src1;
    word_t   src2;
    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    word_t   ex_result;
    word_t   target;
    logic    alu_cond;
    logic    wait_load;
    logic    fire;
    logic    keep;
    logic    taken;
    ex_mem_t ex_next;

    rv_bypass_window u_bypass (
        .clk       (clk),
        .rst       (rst),
        .rs1       (uop.rs1),
        .rs2       (uop.rs2),
        .rf1       (rf1),
        .rf2       (rf2),
        .push      (keep),
        .push_we   (uop.gpr_we),
        .push_load (uop.is_load),
        .push_rd   (uop.rd),
        .push_data (ex_result),
        .load_done (load_done),
        .load_data (load_data),
        .src1      (src1),
        .src2      (src2),
        .wait_load (wait_load)
    );

    assign alu_a = uop.src1_is_pc ? uop.pc : src1;
    assign alu_b = uop.src2_is_imm ? uop.imm : src2;

    rv_alu u_alu (
        .op     (uop.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .cond   (alu_cond)
    );

    // jumps write the link address.
    assign ex_result = (uop.is_jal || uop.is_jalr) ? uop.pc + word_t'(4) : alu_result;
    assign target    = uop.is_jalr ? {alu_result[$bits(word_t)-1:1], 1'b0} : uop.pc + uop.imm;
    assign taken     = (uop.is_branch && alu_cond) || uop.is_jal || uop.is_jalr;

    assign uop_ready = mem_ready && !wait_load;
    assign fire      = uop_valid && uop_ready;
    // shadow of an unacknowledged redirect is discarded.
    assign keep      = fire && !redirect_valid;

    assign ex_next = '{rd:         uop.rd,
                       gpr_we:     uop.gpr_we,
                       is_load:    uop.is_load,
                       is_store:   uop.is_store,
                       result:     ex_result,
                       store_data: src2};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
            ex_out   <= '0;
        end else if (mem_ready) begin
            ex_valid <= keep;
            if (keep) begin
                ex_out <= ex_next;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            redirect_pc    <= '0;
        end else if (redirect_valid) begin
            if (redirect_ack) begin
                redirect_valid <= 1'b0;
            end
        end else if (keep && taken) begin
            redirect_valid <= 1'b1;
            redirect_pc    <= target;
        end
    end

endmodule

//--- verilog/rv_mem_stage.sv
`timescale 1ns/1ps

`include "rv_exec_params.svh"

module rv_mem_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_valid,
    input  rv_exec_pkg::ex_mem_t ex_out,
    output logic                 mem_ready,
    output rv_exec_pkg::wb_t     wb,
    output logic                 load_done,
    output rv_exec_pkg::word_t   load_data
);
    import rv_exec_pkg::*;

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    typedef logic [IDX_W-1:0] dmem_idx_t;

    word_t      dmem [`RV_DMEM_WORDS];
    mem_state_e state;
    dmem_idx_t  idx;
    dmem_idx_t  ld_idx;
    reg_idx_t   ld_rd;
    logic       ld_we;
    logic       accept;

    assign mem_ready = (state == IDLE);
    assign accept    = ex_valid && mem_ready;
    // byte address, low two bits ignored.
    assign idx       = ex_out.result[IDX_W+1:2];
    assign load_data = wb.data;

    // reset exits through LOAD_WAIT with no load owed, so ready rises a cycle late.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= LOAD_WAIT;
            ld_we     <= 1'b0;
            load_done <= 1'b0;
            wb        <= '0;
        end else begin
            load_done <= 1'b0;
            wb.we     <= 1'b0;
            case (state)
                IDLE: begin
                    if (accept && ex_out.is_load) begin
                        state <= LOAD_WAIT;
                        ld_we <= ex_out.gpr_we;
                    end else if (accept && !ex_out.is_store) begin
                        wb.we   <= ex_out.gpr_we && (ex_out.rd != '0);
                        wb.rd   <= ex_out.rd;
                        wb.data <= ex_out.result;
                    end
                end
                LOAD_WAIT: begin
                    state     <= IDLE;
                    load_done <= ld_we;
                    wb.we     <= ld_we && (ld_rd != '0);
                    wb.rd     <= ld_rd;
                    wb.data   <= dmem[ld_idx];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && ex_out.is_load) begin
            ld_rd  <= ex_out.rd;
            ld_idx <= idx;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (accept && ex_out.is_store) begin
            dmem[idx] <= ex_out.store_data;
        end
    end

endmodule

//--- verilog/rv_exec_top.sv
`timescale 1ns/1ps

module rv_exec_top (
    input  logic               clk,
    input  logic               rst,
    input  rv_exec_pkg::uop_t  uop,
    input  logic               uop_valid,
    output logic               uop_ready,
    output rv_exec_pkg::wb_t   wb,
    output logic               redirect_valid,
    output rv_exec_pkg::word_t redirect_pc,
    input  logic               redirect_ack
);
    import rv_exec_pkg::*;

    word_t   rf1;
    word_t   rf2;
    word_t   load_data;
    logic    mem_ready;
    logic    ex_valid;
    logic    load_done;
    ex_mem_t ex_out;

    rv_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .wb     (wb),
        .rs1    (uop.rs1),
        .rs2    (uop.rs2),
        .rdata1 (rf1),
        .rdata2 (rf2)
    );

    rv_exec_stage u_exec (
        .clk            (clk),
        .rst            (rst),
        .uop            (uop),
        .uop_valid      (uop_valid),
        .uop_ready      (uop_ready),
        .rf1            (rf1),
        .rf2            (rf2),
        .mem_ready      (mem_ready),
        .ex_valid       (ex_valid),
        .ex_out         (ex_out),
        .load_done      (load_done),
        .load_data      (load_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ack   (redirect_ack)
    );

    rv_mem_stage u_mem (
        .clk       (clk),
        .rst       (rst),
        .ex_valid  (ex_valid),
        .ex_out    (ex_out),
        .mem_ready (mem_ready),
        .wb        (wb),
        .load_done (load_done),
        .load_data (load_data)
    );

endmodule

//--- tests/rv_exec_clkgen.sv
`timescale 1ns/1ps

module rv_exec_clkgen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD = 50;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // release just after an edge, in step with the stimulus.
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- tests/rv_exec_chk.sv
`timescale 1ns/1ps

module rv_exec_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 ex_valid,
    input rv_exec_pkg::ex_mem_t ex_out,
    input logic                 mem_ready,
    input logic                 redirect_valid,
    input logic                 redirect_ack,
    input rv_exec_pkg::wb_t     wb
);

    logic assert_failed = 1'b0;

    // memory stage back-pressure freezes the execute output register.
    ex_hold: assert property (@(posedge clk) disable iff (rst)
        !mem_ready |=> $stable(ex_valid) && $stable(ex_out))
        else begin
            assert_failed = 1'b1;
            $error("ex_valid or ex_out changed while mem_ready was low");
        end

    redirect_hold: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid)
        else begin
            assert_failed = 1'b1;
            $error("redirect_valid dropped without redirect_ack");
        end

    no_x0_write: assert property (@(posedge clk) disable iff (rst)
        wb.we |-> wb.rd != '0)
        else begin
            assert_failed = 1'b1;
            $error("writeback to x0");
        end

endmodule

bind rv_exec_top rv_exec_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .ex_valid       (ex_valid),
    .ex_out         (ex_out),
    .mem_ready      (mem_ready),
    .redirect_valid (redirect_valid),
    .redirect_ack   (redirect_ack),
    .wb             (wb)
);

//--- tests/rv_exec_tb.sv
`timescale 1ns/1ps

module rv_exec_tb;
    import rv_exec_pkg::*;

    // one observed or expected event, writeback or redirect.
    typedef struct packed {
        logic     redirect;
        reg_idx_t rd;
        word_t    data;
    } exp_evt_t;

    logic     clk;
    logic     rst;
    uop_t     uop;
    logic     uop_valid;
    logic     uop_ready;
    wb_t      wb;
    logic     redirect_valid;
    word_t    redirect_pc;
    logic     redirect_ack;
    logic     redirect_seen;
    int       limit;
    uop_t     uop_q[$];
    logic     shadow_q[$];
    exp_evt_t exp_q[$];

    rv_exec_clkgen u_clkgen (
        .clk (clk),
        .rst (rst)
    );

    rv_exec_top u_rv_exec_top (
        .clk            (clk),
        .rst            (rst),
        .uop            (uop),
        .uop_valid      (uop_valid),
        .uop_ready      (uop_ready),
        .wb             (wb),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .redirect_ack   (redirect_ack)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1, "run aborted");
    endtask

    function automatic string describe(input exp_evt_t e);
        if (e.redirect) begin
            return $sformatf("redirect to %h", e.data);
        end
        return $sformatf("writeback x%0d = %h", e.rd, e.data);
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic read_tests();
        int         fd;
        int         n;
        int         idx[4];
        string      line;
        word_t      pc;
        word_t      imm;
        logic [8:0] flags;
        uop_t       u;
        exp_evt_t   e;
        fd = $fopen("tests/rv_exec_tests.txt", "r");
        assert (fd != 0) else abort_run("could not open tests/rv_exec_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.getc(0) == "U") begin
                n = $sscanf(line, "U %h %h %d %d %d %d %b", pc, imm,
                            idx[0], idx[1], idx[2], idx[3], flags);
                assert (n == 7) else abort_run({"malformed micro-op line: ", line});
                u        = '0;
                u.pc     = pc;
                u.imm    = imm;
                u.rd     = reg_idx_t'(idx[0]);
                u.rs1    = reg_idx_t'(idx[1]);
                u.rs2    = reg_idx_t'(idx[2]);
                u.alu_op = alu_op_e'(idx[3]);
                {u.src1_is_pc, u.src2_is_imm, u.is_branch, u.is_jal, u.is_jalr,
                 u.is_load, u.is_store, u.gpr_we} = flags[8:1];
                uop_q.push_back(u);
                shadow_q.push_back(flags[0]);
            end else if (line.getc(0) == "E") begin
                e = '0;
                if (line.getc(2) == "R") begin
                    e.redirect = 1'b1;
                    n = $sscanf(line, "E R %h", pc);
                    n = n + 1;
                end else begin
                    n = $sscanf(line, "E W %d %h", idx[0], pc);
                    e.rd = reg_idx_t'(idx[0]);
                end
                e.data = pc;
                assert (n == 2) else abort_run({"malformed expected line: ", line});
                exp_q.push_back(e);
            end
        end
        $fclose(fd);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic drive_stream();
        uop_t u;
        logic shadow;
        wait (!rst);
        while (uop_q.size() != 0) begin
            u      = uop_q.pop_front();
            shadow = shadow_q.pop_front();
            // normal micro-ops wait out a pending redirect.
            if (!shadow) begin
                uop_valid = 1'b0;
                while (redirect_valid) begin
                    @(posedge clk);
                    #1;
                end
            end
            uop       = u;
            uop_valid = 1'b1;
            @(negedge clk);
            while (!uop_ready) begin
                @(negedge clk);
            end
            assert (!shadow || redirect_valid)
                else abort_run("a shadow micro-op was accepted after the redirect cleared");
            @(posedge clk);
            #1;
        end
        uop_valid = 1'b0;
        uop       = '0;
    endtask

    task automatic answer_redirects();
        int unsigned delay;
        forever begin
            @(posedge clk);
            #1;
            if (redirect_valid) begin
                delay = $urandom_range(4, 1);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                redirect_ack = 1'b1;
                @(posedge clk);
                #1;
                redirect_ack = 1'b0;
            end
        end
    endtask

    task automatic watch_cycles();
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            assert (cycles < limit)
                else abort_run($sformatf("Timeout: run did not finish in %0d cycles", limit));
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic match_event(input exp_evt_t got);
        exp_evt_t want;
        assert (exp_q.size() != 0)
            else abort_run({"unexpected event after the last expected one: ", describe(got)});
        want = exp_q.pop_front();
        assert (got == want)
            else abort_run($sformatf("Error at time %0t: got %s, expected %s",
                                     $time, describe(got), describe(want)));
    endtask

    // writeback is checked before a redirect seen in the same cycle.
    always @(negedge clk) begin
        if (rst) begin
            redirect_seen = 1'b0;
        end else begin
            assert (!u_rv_exec_top.u_chk.assert_failed)
                else abort_run("a bound protocol assertion failed");
            if (wb.we) begin
                match_event(exp_evt_t'{redirect: 1'b0, rd: wb.rd, data: wb.data});
            end
            if (redirect_valid && !redirect_seen) begin
                match_event(exp_evt_t'{redirect: 1'b1, rd: '0, data: redirect_pc});
            end
            redirect_seen = redirect_valid;
        end
    end

    initial begin
        void'($urandom(66));
        uop          = '0;
        uop_valid    = 1'b0;
        redirect_ack = 1'b0;
        read_tests();
        limit = 20 * uop_q.size() + 50;
        fork
            answer_redirects();
            watch_cycles();
        join_none
        drive_stream();
        for (int i = 0; i < 16 && exp_q.size() != 0; i++) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray retires.
        repeat (4) @(posedge clk);
        #1;
        if (exp_q.size() == 0 && !u_rv_exec_top.u_chk.assert_failed) begin
            $display("Everything OK");
            $finish;
        end else if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected events were never seen", exp_q.size()));
        end else begin
            abort_run("a bound protocol assertion failed");
        end
    end

endmodule

//--- tests/rv_exec_tests.txt
# U pc imm rd rs1 rs2 alu_op flags, flags = s1pc s2imm br jal jalr ld st we shadow
# E W rd data (writeback) or E R target (redirect), all numbers hex except indices
U 00000100 00000005 1 0 0 0 010000010
U 00000104 fffffffd 2 0 0 0 010000010
U 00000108 00000000 3 1 2 0 000000010
U 0000010c 00000000 4 1 3 1 000000010
U 00000110 00000000 5 2 4 4 000000010
U 00000114 00000000 7 2 1 8 000000010
U 00000118 00000004 9 1 0 5 010000010
E W 1 00000005
E W 2 fffffffd
E W 3 00000002
E W 4 00000003
E W 5 fffffffe
E W 7 00000001
E W 9 00000050
# store then load of the same word, then a consumer right behind the load
U 0000011c 00000008 0 0 9 0 010000100
U 00000120 00000008 10 0 0 0 010001010
U 00000124 00000000 11 10 1 0 000000010
E W 10 00000050
E W 11 00000055
# beq not taken, bne and blt taken, bltu not taken, each taken one has a shadow
U 00000128 00000040 0 1 4 10 001000000
U 0000012c 00000028 0 1 4 11 001000000
U 00000130 00000077 12 0 0 0 010000011
U 00000154 00000010 0 2 1 12 001000000
U 00000158 00000099 1 0 0 0 010000011
U 00000164 00000040 0 2 1 14 001000000
E R 00000154
E R 00000164
# jal and jalr
U 00000168 00000100 13 0 0 0 110100010
U 0000016c 00000001 14 0 0 0 010000011
U 00000268 00000007 15 9 0 0 010010010
U 0000026c 00000005 1 1 0 0 010000011
E R 00000268
E W 13 0000016c
E R 00000056
E W 15 0000026c
# write to x0, then read x0 and x1
U 00000056 00000007 0 1 0 0 010000010
U 0000005a 00000000 16 0 1 0 000000010
U 0000005e 00000000 17 2 4 7 000000010
E W 16 00000005
E W 17 ffffffff

//--- build.f
+incdir+include
verilog/rv_exec_pkg.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_bypass_window.sv
verilog/rv_exec_stage.sv
verilog/rv_mem_stage.sv
verilog/rv_exec_top.sv
tests/rv_exec_clkgen.sv
tests/rv_exec_chk.sv
tests/rv_exec_tb.sv

//--- Bender.yml
package:
  name: rv_exec

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_exec_pkg.sv
      - verilog/rv_regfile.sv
      - verilog/rv_alu.sv
      - verilog/rv_bypass_window.sv
      - verilog/rv_exec_stage.sv
      - verilog/rv_mem_stage.sv
      - verilog/rv_exec_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/rv_exec_clkgen.sv
      - tests/rv_exec_chk.sv
      - tests/rv_exec_tb.sv
